// ==== all.f ====
logic/id_pkg.sv
logic/ds_ctrl.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/branch_unit.sv
logic/id_stage.sv
sim/id_stage_checker.sv
sim/tb_id_stage.sv

// ==== sim/tb_id_stage.sv ====
// decode stage testbench
module tb_id_stage;
  import id_pkg::*;

  localparam int TEST_CYCLES = 400;
  localparam int CYCLE_LIMIT = 5 * TEST_CYCLES;
  localparam int FIRE_WAIT   = 20;

  logic      clk;
  logic      rst_n;
  logic      fs_valid;
  inst_t     fs_inst;
  xlen_t     fs_pc;
  logic      ds_allowin;
  logic      es_allowin;
  gpr_addr_t es_rd;
  gpr_addr_t ms_rd;
  gpr_addr_t ws_rd;
  logic      wb_wen;
  gpr_addr_t wb_waddr;
  xlen_t     wb_wdata;
  logic      valid_out;
  xlen_t     pc;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     imm;
  gpr_addr_t rd;
  alu_op_e   alu_op;
  src1_sel_e src1_sel;
  src2_sel_e src2_sel;
  logic      alu_word;
  logic      gpr_wen;
  logic      mem_ren;
  logic      mem_wen;
  mem_op_e   mem_op;
  logic      invalid_inst;
  logic      br_taken;
  xlen_t     br_target;

  int    errors = 0;
  int    cycles = 0;
  xlen_t lcg_state = 64'd71;
  xlen_t gpr_model [32];

  id_stage dut (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_fs_valid (fs_valid), .i_fs_inst (fs_inst), .i_fs_pc (fs_pc),
    .o_ds_allowin (ds_allowin), .i_es_allowin (es_allowin),
    .i_es_rd (es_rd), .i_ms_rd (ms_rd), .i_ws_rd (ws_rd),
    .i_wb_wen (wb_wen), .i_wb_waddr (wb_waddr), .i_wb_wdata (wb_wdata),
    .o_ds_to_es_valid (valid_out), .o_pc (pc),
    .o_rs1_data (rs1_data), .o_rs2_data (rs2_data), .o_imm (imm), .o_rd (rd),
    .o_alu_op (alu_op), .o_alu_src1_sel (src1_sel), .o_alu_src2_sel (src2_sel),
    .o_alu_word (alu_word), .o_gpr_wen (gpr_wen), .o_mem_ren (mem_ren),
    .o_mem_wen (mem_wen), .o_mem_op (mem_op), .o_invalid_inst (invalid_inst),
    .o_br_taken (br_taken), .o_br_target (br_target)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state;
  endfunction

  // instruction encoders
  function automatic inst_t r_type(logic [6:0] f7, gpr_addr_t rs2, gpr_addr_t rs1,
                                   logic [2:0] f3, gpr_addr_t rd_i, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd_i, opc};
  endfunction

  function automatic inst_t i_type(logic [11:0] im, gpr_addr_t rs1, logic [2:0] f3,
                                   gpr_addr_t rd_i, logic [6:0] opc);
    return {im, rs1, f3, rd_i, opc};
  endfunction

  function automatic inst_t s_type(logic [11:0] im, gpr_addr_t rs2, gpr_addr_t rs1,
                                   logic [2:0] f3);
    return {im[11:5], rs2, rs1, f3, im[4:0], OPC_STORE};
  endfunction

  function automatic inst_t b_type(logic [12:0] im, gpr_addr_t rs2, gpr_addr_t rs1,
                                   logic [2:0] f3);
    return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], OPC_BRANCH};
  endfunction

  function automatic inst_t u_type(logic [19:0] im, gpr_addr_t rd_i, logic [6:0] opc);
    return {im, rd_i, opc};
  endfunction

  function automatic inst_t j_type(logic [20:0] im, gpr_addr_t rd_i);
    return {im[20], im[10:1], im[11], im[19:12], rd_i, OPC_JAL};
  endfunction

  task automatic word_eq(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic addr_eq(input string name, input gpr_addr_t exp, input gpr_addr_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic alu_op_eq(input string name, input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic src1_eq(input string name, input src1_sel_e exp, input src1_sel_e act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic src2_eq(input string name, input src2_sel_e exp, input src2_sel_e act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic mem_op_eq(input string name, input mem_op_e exp, input mem_op_e act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic bit_eq(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic write_gpr(input gpr_addr_t addr, input xlen_t data);
    @(negedge clk);
    wb_wen   = 1'b1;
    wb_waddr = addr;
    wb_wdata = data;
    @(negedge clk);
    wb_wen = 1'b0;
    if (addr != 5'd0) gpr_model[addr] = data;
  endtask

  // returns on the falling edge after the accepting edge
  task automatic issue_inst(input inst_t inst, input xlen_t at_pc);
    int n;
    n = 0;
    @(negedge clk);
    fs_valid = 1'b1;
    fs_inst  = inst;
    fs_pc    = at_pc;
    @(posedge clk);
    while (!ds_allowin && n < FIRE_WAIT) begin
      n++;
      @(posedge clk);
    end
    if (!ds_allowin) begin
      $display("instruction at pc %h was not accepted within %0d cycles", at_pc, FIRE_WAIT);
      errors++;
    end
    @(negedge clk);
    fs_valid = 1'b0;
  endtask

  // outputs are checked at the fire edge, before it updates the stage
  task automatic wait_fire(input xlen_t at_pc);
    int n;
    n = 0;
    @(posedge clk);
    while (!(valid_out && es_allowin) && n < FIRE_WAIT) begin
      n++;
      @(posedge clk);
    end
    if (!(valid_out && es_allowin)) begin
      $display("instruction at pc %h did not leave within %0d cycles", at_pc, FIRE_WAIT);
      errors++;
    end
  endtask

  task automatic send_and_fire(input inst_t inst, input xlen_t at_pc);
    issue_inst(inst, at_pc);
    wait_fire(at_pc);
    word_eq("o_pc", at_pc, pc);
  endtask

  task automatic fires_at_once();
    @(posedge clk);
    bit_eq("o_ds_to_es_valid", 1'b1, valid_out);
  endtask

  task automatic expect_alu(input gpr_addr_t e_rd, input alu_op_e e_op,
                            input src2_sel_e e_src2, input logic e_word);
    addr_eq("o_rd", e_rd, rd);
    alu_op_eq("o_alu_op", e_op, alu_op);
    src2_eq("o_alu_src2_sel", e_src2, src2_sel);
    bit_eq("o_alu_word", e_word, alu_word);
    bit_eq("o_gpr_wen", 1'b1, gpr_wen);
  endtask

  task automatic alu_imm_decode();
    for (int i = 1; i < 32; i++) write_gpr(gpr_addr_t'(i), lcg_next());
    send_and_fire(i_type(12'hffb, 5'd3, 3'b000, 5'd5, OPC_OPIMM), 64'h100);  // addi
    word_eq("o_rs1_data", gpr_model[3], rs1_data);
    word_eq("o_imm", 64'hffff_ffff_ffff_fffb, imm);
    expect_alu(5'd5, ALU_ADD, SRC2_IMM, 1'b0);
    src1_eq("o_alu_src1_sel", SRC1_RS1, src1_sel);
    send_and_fire(i_type(12'h00d, 5'd7, 3'b001, 5'd6, OPC_OPIMM), 64'h104);  // slli
    word_eq("o_rs1_data", gpr_model[7], rs1_data);
    word_eq("o_imm", 64'd13, imm);
    expect_alu(5'd6, ALU_SLL, SRC2_IMM, 1'b0);
    send_and_fire(u_type(20'h80001, 5'd8, OPC_LUI), 64'h108);
    word_eq("o_imm", 64'hffff_ffff_8000_1000, imm);
    expect_alu(5'd8, ALU_COPY2, SRC2_IMM, 1'b0);
    send_and_fire(u_type(20'h12345, 5'd9, OPC_AUIPC), 64'h1000);
    word_eq("o_imm", 64'h0000_0000_1234_5000, imm);
    expect_alu(5'd9, ALU_ADD, SRC2_IMM, 1'b0);
    src1_eq("o_alu_src1_sel", SRC1_PC, src1_sel);
    send_and_fire(r_type(7'h20, 5'd12, 5'd11, 3'b000, 5'd10, OPC_OP), 64'h1004);  // sub
    word_eq("o_rs1_data", gpr_model[11], rs1_data);
    word_eq("o_rs2_data", gpr_model[12], rs2_data);
    expect_alu(5'd10, ALU_SUB, SRC2_RS2, 1'b0);
    send_and_fire(r_type(7'h20, 5'd15, 5'd14, 3'b101, 5'd13, OPC_OP32), 64'h1008);  // sraw
    word_eq("o_rs2_data", gpr_model[15], rs2_data);
    expect_alu(5'd13, ALU_SRA, SRC2_RS2, 1'b1);
    send_and_fire(i_type(12'h7ff, 5'd17, 3'b000, 5'd16, OPC_OPIMM32), 64'h100c);  // addiw
    word_eq("o_imm", 64'h7ff, imm);
    expect_alu(5'd16, ALU_ADD, SRC2_IMM, 1'b1);
  endtask

  task automatic regfile_rw();
    xlen_t v;
    xlen_t old;
    v = lcg_next();
    write_gpr(5'd20, v);
    send_and_fire(r_type(7'h00, 5'd0, 5'd20, 3'b000, 5'd1, OPC_OP), 64'h2000);
    word_eq("o_rs1_data", v, rs1_data);
    word_eq("o_rs2_data", 64'd0, rs2_data);
    write_gpr(5'd0, lcg_next());
    send_and_fire(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, OPC_OP), 64'h2004);
    word_eq("o_rs1_data", 64'd0, rs1_data);
    old = gpr_model[21];
    v   = lcg_next();
    @(negedge clk);
    es_allowin = 1'b0;
    issue_inst(r_type(7'h00, 5'd22, 5'd21, 3'b000, 5'd2, OPC_OP), 64'h2008);
    wb_wen   = 1'b1;
    wb_waddr = 5'd21;
    wb_wdata = v;
    @(posedge clk);
    word_eq("o_rs1_data", old, rs1_data);  // write lands at this edge
    @(negedge clk);
    wb_wen = 1'b0;
    gpr_model[21] = v;
    @(posedge clk);
    word_eq("o_rs1_data", v, rs1_data);
    @(negedge clk);
    es_allowin = 1'b1;
    wait_fire(64'h2008);
    word_eq("o_rs2_data", gpr_model[22], rs2_data);
  endtask

  task automatic resolve_branch(input inst_t inst, input xlen_t at_pc, input logic taken,
                                input xlen_t target, input logic hold);
    if (hold) begin
      @(negedge clk);
      es_allowin = 1'b0;
    end
    issue_inst(inst, at_pc);
    if (hold) begin
      repeat (3) begin
        @(posedge clk);
        bit_eq("o_br_taken", 1'b0, br_taken);
      end
      @(negedge clk);
      es_allowin = 1'b1;
    end
    wait_fire(at_pc);
    bit_eq("o_br_taken", taken, br_taken);
    if (taken) word_eq("o_br_target", target, br_target);
  endtask

  task automatic branch_jump();
    xlen_t a;
    xlen_t b;
    a = gpr_model[3];
    b = gpr_model[4];
    resolve_branch(b_type(13'h0040, 5'd3, 5'd3, 3'b000), 64'h3000, 1'b1, 64'h3040, 1'b0);
    resolve_branch(b_type(13'h0040, 5'd4, 5'd3, 3'b000), 64'h3004, a == b, 64'h3044, 1'b0);
    resolve_branch(b_type(13'h1ff0, 5'd4, 5'd3, 3'b001), 64'h3008, a != b, 64'h2ff8, 1'b1);
    resolve_branch(b_type(13'h0020, 5'd4, 5'd3, 3'b100), 64'h300c,
                   $signed(a) < $signed(b), 64'h302c, 1'b0);
    resolve_branch(b_type(13'h0020, 5'd3, 5'd4, 3'b100), 64'h3010,
                   $signed(b) < $signed(a), 64'h3030, 1'b0);
    resolve_branch(b_type(13'h0100, 5'd4, 5'd3, 3'b111), 64'h3014, a >= b, 64'h3114, 1'b0);
    resolve_branch(b_type(13'h0100, 5'd3, 5'd4, 3'b111), 64'h3018, b >= a, 64'h3118, 1'b0);
    write_gpr(5'd5, 64'h1000);
    resolve_branch(j_type(21'h000800, 5'd1), 64'h3100, 1'b1, 64'h3900, 1'b0);
    // 0x1000 + 3 with bit 0 dropped
    resolve_branch(i_type(12'h003, 5'd5, 3'b000, 5'd1, OPC_JALR), 64'h3104,
                   1'b1, 64'h1002, 1'b1);
  endtask

  task automatic hazard_stall();
    @(negedge clk);
    ms_rd = 5'd9;
    issue_inst(r_type(7'h00, 5'd9, 5'd8, 3'b000, 5'd7, OPC_OP), 64'h4000);
    repeat (3) begin
      @(posedge clk);
      bit_eq("o_ds_to_es_valid", 1'b0, valid_out);
      bit_eq("o_ds_allowin", 1'b0, ds_allowin);
    end
    @(negedge clk);
    ms_rd = 5'd0;
    wait_fire(64'h4000);
    word_eq("o_rs2_data", gpr_model[9], rs2_data);
    issue_inst(r_type(7'h00, 5'd9, 5'd0, 3'b000, 5'd7, OPC_OP), 64'h4004);  // rs1 x0, es_rd 0
    fires_at_once();
    @(negedge clk);
    ms_rd = 5'd9;
    issue_inst(i_type(12'h009, 5'd8, 3'b000, 5'd7, OPC_OPIMM), 64'h4008);  // rs2 field unused
    fires_at_once();
    @(negedge clk);
    ms_rd = 5'd0;
  endtask

  task automatic backpressure_mem();
    @(negedge clk);
    es_allowin = 1'b0;
    issue_inst(i_type(12'h008, 5'd2, 3'b011, 5'd10, OPC_LOAD), 64'h5000);  // ld
    fs_valid = 1'b1;
    fs_inst  = s_type(12'hfec, 5'd6, 5'd2, 3'b001);  // sh waits in fetch
    fs_pc    = 64'h5004;
    repeat (3) begin
      @(posedge clk);
      bit_eq("o_ds_allowin", 1'b0, ds_allowin);
      word_eq("o_pc", 64'h5000, pc);
    end
    @(negedge clk);
    es_allowin = 1'b1;
    @(posedge clk);
    bit_eq("o_ds_to_es_valid", 1'b1, valid_out);
    bit_eq("o_mem_ren", 1'b1, mem_ren);
    bit_eq("o_mem_wen", 1'b0, mem_wen);
    mem_op_eq("o_mem_op", MEM_D, mem_op);
    word_eq("o_imm", 64'd8, imm);
    addr_eq("o_rd", 5'd10, rd);
    @(negedge clk);
    fs_valid = 1'b0;
    wait_fire(64'h5004);
    word_eq("o_pc", 64'h5004, pc);
    bit_eq("o_mem_ren", 1'b0, mem_ren);
    bit_eq("o_mem_wen", 1'b1, mem_wen);
    bit_eq("o_gpr_wen", 1'b0, gpr_wen);
    mem_op_eq("o_mem_op", MEM_H, mem_op);
    word_eq("o_imm", 64'hffff_ffff_ffff_ffec, imm);
    word_eq("o_rs2_data", gpr_model[6], rs2_data);
  endtask

  task automatic invalid_decode();
    inst_t bad [3];
    bad[0] = 32'h0000_0073;  // ecall
    bad[1] = i_type(12'h300, 5'd2, 3'b001, 5'd1, 7'b1110011);  // csrrw
    bad[2] = r_type(7'b0010000, 5'd3, 5'd2, 3'b000, 5'd1, OPC_OP);
    foreach (bad[i]) begin
      send_and_fire(bad[i], 64'h6000 + 64'(4 * i));
      bit_eq("o_invalid_inst", 1'b1, invalid_inst);
      bit_eq("o_gpr_wen", 1'b0, gpr_wen);
      bit_eq("o_mem_ren", 1'b0, mem_ren);
      bit_eq("o_mem_wen", 1'b0, mem_wen);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_inst    = '0;
    fs_pc      = '0;
    es_allowin = 1'b1;
    es_rd      = '0;
    ms_rd      = '0;
    ws_rd      = '0;
    wb_wen     = 1'b0;
    wb_waddr   = '0;
    wb_wdata   = '0;
    foreach (gpr_model[i]) gpr_model[i] = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    bit_eq("o_ds_to_es_valid", 1'b0, valid_out);
    bit_eq("o_ds_allowin", 1'b1, ds_allowin);
    bit_eq("o_br_taken", 1'b0, br_taken);
    bit_eq("o_invalid_inst", 1'b1, invalid_inst);  // zero latch
    alu_imm_decode();
    regfile_rw();
    branch_jump();
    hazard_stall();
    backpressure_mem();
    invalid_decode();
    @(negedge clk);
    $display("errors: %0d, assertion failures: %0d, after %0d cycles",
             errors, dut.u_checker.fail_count, cycles);
    if (errors == 0 && dut.u_checker.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== sim/id_stage_checker.sv ====
// decode stage handshake assertions
module id_stage_checker (
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_ds_valid,
  input logic              i_valid_out,
  input logic              i_es_allowin,
  input logic              i_allowin,
  input logic              i_br_taken,
  input id_pkg::xlen_t     i_pc,
  input id_pkg::gpr_addr_t i_rd
);

  logic fire;
  int   fail_count = 0;

  assign fire = i_valid_out && i_es_allowin;

  a_quiet_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_valid_out)
    else begin
      $error("valid out high in first cycle after reset");
      fail_count++;
    end

  // redirect only from a leaving instruction
  a_taken_needs_fire: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_taken |-> (i_valid_out && i_es_allowin))
    else begin
      $error("branch taken without fire");
      fail_count++;
    end

  a_held_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_valid && !i_es_allowin) |=> ($stable(i_pc) && $stable(i_rd)))
    else begin
      $error("held instruction changed under back-pressure");
      fail_count++;
    end

  // a held instruction blocks fetch and stays in place
  a_no_allowin_when_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_valid && !fire) |-> !i_allowin ##1 (i_ds_valid && $stable(i_pc)))
    else begin
      $error("allowin high or instruction lost while held");
      fail_count++;
    end

endmodule

bind id_stage id_stage_checker u_checker (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_ds_valid   (u_ds_ctrl.ds_valid),
  .i_valid_out  (o_ds_to_es_valid),
  .i_es_allowin (i_es_allowin),
  .i_allowin    (o_ds_allowin),
  .i_br_taken   (o_br_taken),
  .i_pc         (o_pc),
  .i_rd         (o_rd)
);

// ==== logic/id_stage.sv ====
// instruction decode stage
module id_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  // from fetch
  input  logic              i_fs_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::xlen_t     i_fs_pc,
  output logic              o_ds_allowin,
  // later stage destinations
  input  logic              i_es_allowin,
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_addr_t i_ws_rd,
  // write back into gprs
  input  logic              i_wb_wen,
  input  id_pkg::gpr_addr_t i_wb_waddr,
  input  id_pkg::xlen_t     i_wb_wdata,
  // to execute
  output logic              o_ds_to_es_valid,
  output id_pkg::xlen_t     o_pc,
  output id_pkg::xlen_t     o_rs1_data,
  output id_pkg::xlen_t     o_rs2_data,
  output id_pkg::xlen_t     o_imm,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::alu_op_e   o_alu_op,
  output id_pkg::src1_sel_e o_alu_src1_sel,
  output id_pkg::src2_sel_e o_alu_src2_sel,
  output logic              o_alu_word,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output id_pkg::mem_op_e   o_mem_op,
  output logic              o_invalid_inst,
  // redirect to fetch
  output logic              o_br_taken,
  output id_pkg::xlen_t     o_br_target
);
  import id_pkg::*;

  inst_t     ds_inst;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  logic      rs1_used;
  logic      rs2_used;
  logic      fire;
  br_func_e  br_func;
  logic      is_jalr;

  assign is_jalr = (ds_inst[6:0] == OPC_JALR);

  ds_ctrl u_ds_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_rs1_used       (rs1_used),
    .i_rs2_used       (rs2_used),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_fire           (fire),
    .o_inst           (ds_inst),
    .o_pc             (o_pc)
  );

  inst_decoder u_inst_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_rs1_used     (rs1_used),
    .o_rs2_used     (rs2_used),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_sel (o_alu_src1_sel),
    .o_alu_src2_sel (o_alu_src2_sel),
    .o_alu_word     (o_alu_word),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_br_func      (br_func),
    .o_invalid_inst (o_invalid_inst)
  );

  gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (o_rs1_data),
    .i_raddr2 (rs2),
    .o_rdata2 (o_rs2_data),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata)
  );

  branch_unit u_branch_unit (
    .i_fire      (fire),
    .i_br_func   (br_func),
    .i_is_jalr   (is_jalr),
    .i_pc        (o_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_imm       (o_imm),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

// ==== logic/branch_unit.sv ====
// branch and jump resolution
module branch_unit (
  input  logic             i_fire,
  input  id_pkg::br_func_e i_br_func,
  input  logic             i_is_jalr,
  input  id_pkg::xlen_t    i_pc,
  input  id_pkg::xlen_t    i_rs1_data,
  input  id_pkg::xlen_t    i_rs2_data,
  input  id_pkg::xlen_t    i_imm,
  output logic             o_br_taken,
  output id_pkg::xlen_t    o_br_target
);
  import id_pkg::*;

  logic  cond;
  logic  eq;
  logic  lt;
  logic  ltu;
  xlen_t jalr_sum;
  xlen_t pc_rel;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      BR_EQ:   cond = eq;
      BR_NE:   cond = !eq;
      BR_LT:   cond = lt;
      BR_GE:   cond = !lt;
      BR_LTU:  cond = ltu;
      BR_GEU:  cond = !ltu;
      BR_JUMP: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign pc_rel   = i_pc + i_imm;
  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br_target = i_is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc_rel;
  // held branch stays quiet until it leaves
  assign o_br_taken  = i_fire && cond;

endmodule

// ==== logic/gpr_file.sv ====
// general purpose registers
module gpr_file (
  input  logic              i_clk,
  // read port 1
  input  id_pkg::gpr_addr_t i_raddr1,
  output id_pkg::xlen_t     o_rdata1,
  // read port 2
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::xlen_t     o_rdata2,
  // write port
  input  logic              i_wen,
  input  id_pkg::gpr_addr_t i_waddr,
  input  id_pkg::xlen_t     i_wdata
);
  import id_pkg::*;

  xlen_t regs [32];

  // x0 is never written
  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, same cycle write shows next cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== logic/inst_decoder.sv ====
// rv64i instruction decoder
module inst_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output logic              o_rs1_used,
  output logic              o_rs2_used,
  output id_pkg::xlen_t     o_imm,
  output id_pkg::alu_op_e   o_alu_op,
  output id_pkg::src1_sel_e o_alu_src1_sel,
  output id_pkg::src2_sel_e o_alu_src2_sel,
  output logic              o_alu_word,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output id_pkg::mem_op_e   o_mem_op,
  output id_pkg::br_func_e  o_br_func,
  output logic              o_invalid_inst
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  alu_op_e    f3_op;
  alu_op_e    sh_op;
  alu_op_e    rr_op;
  logic       op_legal;
  logic       op32_legal;
  logic       opimm_legal;
  logic       opimm32_legal;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = o_gpr_wen ? i_inst[11:7] : '0;  // zero tags a non-writer

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'b000:  f3_op = ALU_ADD;
      3'b001:  f3_op = ALU_SLL;
      3'b010:  f3_op = ALU_SLT;
      3'b011:  f3_op = ALU_SLTU;
      3'b100:  f3_op = ALU_XOR;
      3'b101:  f3_op = ALU_SRL;
      3'b110:  f3_op = ALU_OR;
      default: f3_op = ALU_AND;
    endcase
  end

  // bit 30 picks sra, and sub for register ops only
  assign sh_op = (funct3 == 3'b101 && i_inst[30]) ? ALU_SRA : f3_op;
  assign rr_op = (funct3 == 3'b000 && i_inst[30]) ? ALU_SUB : sh_op;

  assign op_legal = (funct7 == 7'b0000000)
                 || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign op32_legal = op_legal && (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101);
  // rv64 shamt is 6 bits, so only imm[11:6] is checked
  assign opimm_legal = (funct3 == 3'b001) ? (i_inst[31:26] == 6'b000000) :
                       (funct3 == 3'b101) ? (i_inst[31:26] == 6'b000000 ||
                                             i_inst[31:26] == 6'b010000) : 1'b1;
  assign opimm32_legal = (funct3 == 3'b000)
                      || (funct3 == 3'b001 && funct7 == 7'b0000000)
                      || (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000));

  always_comb begin
    o_rs1_used     = 1'b1;
    o_rs2_used     = 1'b0;
    o_imm          = imm_i;
    o_alu_op       = ALU_ADD;
    o_alu_src1_sel = SRC1_RS1;
    o_alu_src2_sel = SRC2_IMM;
    o_alu_word     = 1'b0;
    o_gpr_wen      = 1'b1;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_mem_op       = MEM_B;
    o_br_func      = BR_NONE;
    o_invalid_inst = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_rs1_used = 1'b0;
        o_imm      = imm_u;
        o_alu_op   = ALU_COPY2;
      end
      OPC_AUIPC: begin
        o_rs1_used     = 1'b0;
        o_imm          = imm_u;
        o_alu_src1_sel = SRC1_PC;
      end
      OPC_JAL, OPC_JALR: begin
        o_rs1_used     = (opcode == OPC_JALR);
        o_imm          = (opcode == OPC_JALR) ? imm_i : imm_j;
        o_alu_src1_sel = SRC1_PC;  // link = pc + 4
        o_alu_src2_sel = SRC2_FOUR;
        o_br_func      = BR_JUMP;
        o_invalid_inst = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_rs2_used = 1'b1;
        o_imm      = imm_b;
        o_gpr_wen  = 1'b0;
        case (funct3)
          3'b000:  o_br_func = BR_EQ;
          3'b001:  o_br_func = BR_NE;
          3'b100:  o_br_func = BR_LT;
          3'b101:  o_br_func = BR_GE;
          3'b110:  o_br_func = BR_LTU;
          3'b111:  o_br_func = BR_GEU;
          default: o_invalid_inst = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        o_mem_ren      = 1'b1;
        o_invalid_inst = (funct3 == 3'b111);
        if (funct3 != 3'b111) begin
          o_mem_op = mem_op_e'(funct3);
        end
      end
      OPC_STORE: begin
        o_rs2_used     = 1'b1;
        o_imm          = imm_s;
        o_gpr_wen      = 1'b0;
        o_mem_wen      = 1'b1;
        o_mem_op       = mem_op_e'({1'b0, funct3[1:0]});
        o_invalid_inst = funct3[2];
      end
      OPC_OPIMM: begin
        o_alu_op       = sh_op;
        o_invalid_inst = !opimm_legal;
      end
      OPC_OPIMM32: begin
        o_alu_op       = sh_op;
        o_alu_word     = 1'b1;
        o_invalid_inst = !opimm32_legal;
      end
      OPC_OP, OPC_OP32: begin
        o_rs2_used     = 1'b1;
        o_alu_op       = rr_op;
        o_alu_src2_sel = SRC2_RS2;
        o_alu_word     = (opcode == OPC_OP32);
        o_invalid_inst = (opcode == OPC_OP32) ? !op32_legal : !op_legal;
      end
      default: o_invalid_inst = 1'b1;  // system, csr, fence, unknown
    endcase
    if (o_invalid_inst) begin
      o_rs1_used = 1'b0;
      o_rs2_used = 1'b0;
      o_gpr_wen  = 1'b0;
      o_mem_ren  = 1'b0;
      o_mem_wen  = 1'b0;
      o_br_func  = BR_NONE;
    end
  end

endmodule

// ==== logic/ds_ctrl.sv ====
// decode stage control
module ds_ctrl (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_fs_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::xlen_t     i_fs_pc,
  input  logic              i_es_allowin,
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  logic              i_rs1_used,
  input  logic              i_rs2_used,
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_addr_t i_ws_rd,
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output logic              o_fire,
  output id_pkg::inst_t     o_inst,
  output id_pkg::xlen_t     o_pc
);
  import id_pkg::*;

  logic ds_valid;
  logic ds_ready_go;
  logic hazard;
  logic accept;

  // rd of zero means the later stage writes nothing
  function automatic logic rd_match(input gpr_addr_t rd,
                                    input gpr_addr_t rs1,
                                    input logic      rs1_used,
                                    input gpr_addr_t rs2,
                                    input logic      rs2_used);
    return (rd != '0) && ((rs1_used && rd == rs1) || (rs2_used && rd == rs2));
  endfunction

  assign hazard = rd_match(i_es_rd, i_rs1, i_rs1_used, i_rs2, i_rs2_used)
               || rd_match(i_ms_rd, i_rs1, i_rs1_used, i_rs2, i_rs2_used)
               || rd_match(i_ws_rd, i_rs1, i_rs1_used, i_rs2, i_rs2_used);

  assign ds_ready_go      = !hazard;
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_fire           = o_ds_to_es_valid && i_es_allowin;
  assign o_ds_allowin     = !ds_valid || o_fire;
  assign accept           = i_fs_valid && o_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;  // refill or drain
    end
  end

  // zero inst after reset decodes as invalid
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_inst <= '0;
      o_pc   <= '0;
    end else if (accept) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

// ==== logic/id_pkg.sv ====
// id stage shared definitions
package id_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      gpr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_COPY2  // operand 2 straight through, lui
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1,
    SRC1_PC
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR  // link value
  } src2_sel_e;

  // same encoding as funct3
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JUMP
  } br_func_e;

  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP32    = 7'b0111011;

endpackage
